/* Bender.yml */
package:
  name: dual_alu

sources:
  - hdl/alu_pkg.sv
  - hdl/popcount.sv
  - hdl/alu.sv
  - hdl/dual_alu_wrap.sv
  - hdl/pair_issue_slave.sv
  - hdl/result_return_master.sv
  - hdl/dual_alu_top.sv
  - target: test
    files:
      - verification/dual_alu_tb.sv

/* dual_alu_top.f */
hdl/alu_pkg.sv
hdl/popcount.sv
hdl/alu.sv
hdl/dual_alu_wrap.sv
hdl/pair_issue_slave.sv
hdl/result_return_master.sv
hdl/dual_alu_top.sv
verification/dual_alu_tb.sv

/* hdl/alu.sv */
`default_nettype none

module alu
    import alu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [OP_W-1:0] op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_res_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    assign shamt = b_i[SHAMT_W-1:0];  // Upper bits of B are ignored for shifts
    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    always_comb begin
        case (op_i)
            OP_EQ:   branch_res_o = eq;
            OP_NE:   branch_res_o = ~eq;
            OP_LT:   branch_res_o = lt_s;
            OP_GE:   branch_res_o = ~lt_s;
            OP_LTU:  branch_res_o = lt_u;
            OP_GEU:  branch_res_o = ~lt_u;
            default: branch_res_o = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            OP_SLT:  result_o = XLEN'(lt_s);
            OP_SLTU: result_o = XLEN'(lt_u);
            OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU: begin
                result_o = XLEN'(branch_res_o);
            end
            default: result_o = '0;  // CPOP and CPOPW are filled in by the wrapper
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int OP_W = 5;

    // Arithmetic and logic
    localparam logic [OP_W-1:0] OP_ADD   = 5'd0;
    localparam logic [OP_W-1:0] OP_SUB   = 5'd1;
    localparam logic [OP_W-1:0] OP_AND   = 5'd2;
    localparam logic [OP_W-1:0] OP_OR    = 5'd3;
    localparam logic [OP_W-1:0] OP_XOR   = 5'd4;
    localparam logic [OP_W-1:0] OP_SLL   = 5'd5;
    localparam logic [OP_W-1:0] OP_SRL   = 5'd6;
    localparam logic [OP_W-1:0] OP_SRA   = 5'd7;
    localparam logic [OP_W-1:0] OP_SLT   = 5'd8;
    localparam logic [OP_W-1:0] OP_SLTU  = 5'd9;

    // Branch compares, the outcome also goes to the branch output
    localparam logic [OP_W-1:0] OP_EQ    = 5'd10;
    localparam logic [OP_W-1:0] OP_NE    = 5'd11;
    localparam logic [OP_W-1:0] OP_LT    = 5'd12;
    localparam logic [OP_W-1:0] OP_GE    = 5'd13;
    localparam logic [OP_W-1:0] OP_LTU   = 5'd14;
    localparam logic [OP_W-1:0] OP_GEU   = 5'd15;

    localparam logic [OP_W-1:0] OP_CPOP  = 5'd16;
    localparam logic [OP_W-1:0] OP_CPOPW = 5'd17;  // Counts the low word only

    localparam int FUSE_W   = 2;
    localparam int FUSE_RS1 = 0;  // Lane 0 operand A takes lane 1 result
    localparam int FUSE_RS2 = 1;  // Lane 0 operand B takes lane 1 result

endpackage

`default_nettype wire

/* hdl/dual_alu_top.sv */
`default_nettype none

module dual_alu_top
    import alu_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter bit HAS_CPOP = 1'b1
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    output logic              ack_o,
    input  logic [FUSE_W-1:0] fuse_i,
    input  logic [OP_W-1:0]   op0_i,
    input  logic [OP_W-1:0]   op1_i,
    input  logic [XLEN-1:0]   a0_i,
    input  logic [XLEN-1:0]   b0_i,
    input  logic [XLEN-1:0]   a1_i,
    input  logic [XLEN-1:0]   b1_i,
    output logic              res_req_o,
    input  logic              res_ack_i,
    output logic [XLEN-1:0]   res0_o,
    output logic [XLEN-1:0]   res1_o,
    output logic              branch_o
);

    logic [FUSE_W-1:0] fuse_q;
    logic [OP_W-1:0]   op0_q;
    logic [OP_W-1:0]   op1_q;
    logic [XLEN-1:0]   a0_q;
    logic [XLEN-1:0]   b0_q;
    logic [XLEN-1:0]   a1_q;
    logic [XLEN-1:0]   b1_q;
    logic              full;
    logic              take;
    logic [XLEN-1:0]   res0;
    logic [XLEN-1:0]   res1;
    logic              branch;

    pair_issue_slave #(
        .XLEN(XLEN)
    ) u_slave (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .req_i   (req_i),
        .fuse_i  (fuse_i),
        .op0_i   (op0_i),
        .op1_i   (op1_i),
        .a0_i    (a0_i),
        .b0_i    (b0_i),
        .a1_i    (a1_i),
        .b1_i    (b1_i),
        .take_i  (take),
        .ack_o   (ack_o),
        .full_o  (full),
        .fuse_o  (fuse_q),
        .op0_o   (op0_q),
        .op1_o   (op1_q),
        .a0_o    (a0_q),
        .b0_o    (b0_q),
        .a1_o    (a1_q),
        .b1_o    (b1_q)
    );

    dual_alu_wrap #(
        .XLEN    (XLEN),
        .HAS_CPOP(HAS_CPOP)
    ) u_dual_alu (
        .fuse_i      (fuse_q),
        .op0_i       (op0_q),
        .op1_i       (op1_q),
        .a0_i        (a0_q),
        .b0_i        (b0_q),
        .a1_i        (a1_q),
        .b1_i        (b1_q),
        .res0_o      (res0),
        .res1_o      (res1),
        .branch_res_o(branch)
    );

    result_return_master #(
        .XLEN(XLEN)
    ) u_master (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .full_i   (full),
        .res0_i   (res0),
        .res1_i   (res1),
        .branch_i (branch),
        .res_ack_i(res_ack_i),
        .take_o   (take),
        .res_req_o(res_req_o),
        .res0_o   (res0_o),
        .res1_o   (res1_o),
        .branch_o (branch_o)
    );

endmodule

`default_nettype wire

/* hdl/dual_alu_wrap.sv */
`default_nettype none

module dual_alu_wrap
    import alu_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter bit HAS_CPOP = 1'b1
) (
    input  logic [FUSE_W-1:0] fuse_i,
    input  logic [OP_W-1:0]   op0_i,
    input  logic [OP_W-1:0]   op1_i,
    input  logic [XLEN-1:0]   a0_i,
    input  logic [XLEN-1:0]   b0_i,
    input  logic [XLEN-1:0]   a1_i,
    input  logic [XLEN-1:0]   b1_i,
    output logic [XLEN-1:0]   res0_o,
    output logic [XLEN-1:0]   res1_o,
    output logic              branch_res_o
);

    localparam int CNT_W = $clog2(XLEN) + 1;
    localparam logic [XLEN-1:0] LOW_WORD = XLEN'(64'h0000_0000_ffff_ffff);

    logic [XLEN-1:0]  fused_a0;
    logic [XLEN-1:0]  fused_b0;
    logic [XLEN-1:0]  alu_res0;
    logic [XLEN-1:0]  alu_res1;
    logic [OP_W-1:0]  lane_op [2];
    logic [XLEN-1:0]  lane_a  [2];
    logic [CNT_W-1:0] cpop    [2];

    assign fused_a0 = fuse_i[FUSE_RS1] ? alu_res1 : a0_i;
    assign fused_b0 = fuse_i[FUSE_RS2] ? alu_res1 : b0_i;

    alu #(
        .XLEN(XLEN)
    ) u_alu0 (
        .op_i        (op0_i),
        .a_i         (fused_a0),
        .b_i         (fused_b0),
        .result_o    (alu_res0),
        .branch_res_o()  // Only lane 1 resolves branches
    );

    alu #(
        .XLEN(XLEN)
    ) u_alu1 (
        .op_i        (op1_i),
        .a_i         (a1_i),
        .b_i         (b1_i),
        .result_o    (alu_res1),
        .branch_res_o(branch_res_o)
    );

    assign lane_op[0] = op0_i;
    assign lane_op[1] = op1_i;
    assign lane_a[0]  = a0_i;  // Popcount always sees the unfused operand
    assign lane_a[1]  = a1_i;

    for (genvar l = 0; l < 2; l++) begin : gen_lane
        if (HAS_CPOP) begin : gen_cpop
            logic [XLEN-1:0] cpop_in;

            // The mask is all ones at XLEN 32, so CPOPW only differs at XLEN 64
            assign cpop_in = (lane_op[l] == OP_CPOPW) ? (lane_a[l] & LOW_WORD) : lane_a[l];

            popcount #(
                .INPUT_WIDTH(XLEN)
            ) u_popcount (
                .data_i    (cpop_in),
                .popcount_o(cpop[l])
            );
        end else begin : gen_no_cpop
            assign cpop[l] = '0;
        end
    end

    assign res0_o = (op0_i inside {OP_CPOP, OP_CPOPW}) ? XLEN'(cpop[0]) : alu_res0;
    assign res1_o = (op1_i inside {OP_CPOP, OP_CPOPW}) ? XLEN'(cpop[1]) : alu_res1;

endmodule

`default_nettype wire

/* hdl/pair_issue_slave.sv */
`default_nettype none

module pair_issue_slave
    import alu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  logic [FUSE_W-1:0] fuse_i,
    input  logic [OP_W-1:0]   op0_i,
    input  logic [OP_W-1:0]   op1_i,
    input  logic [XLEN-1:0]   a0_i,
    input  logic [XLEN-1:0]   b0_i,
    input  logic [XLEN-1:0]   a1_i,
    input  logic [XLEN-1:0]   b1_i,
    input  logic              take_i,
    output logic              ack_o,
    output logic              full_o,
    output logic [FUSE_W-1:0] fuse_o,
    output logic [OP_W-1:0]   op0_o,
    output logic [OP_W-1:0]   op1_o,
    output logic [XLEN-1:0]   a0_o,
    output logic [XLEN-1:0]   b0_o,
    output logic [XLEN-1:0]   a1_o,
    output logic [XLEN-1:0]   b1_o
);

    logic capture;

    // A pair is refused while the previous one still sits in the holding register
    assign capture = req_i & ~ack_o & ~full_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o  <= 1'b0;
            full_o <= 1'b0;
        end else begin
            if (capture) begin
                ack_o <= 1'b1;
            end else if (ack_o && !req_i) begin
                ack_o <= 1'b0;  // Sender has dropped req, close the handshake
            end
            if (capture) begin
                full_o <= 1'b1;
            end else if (take_i) begin
                full_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fuse_o <= '0;
            op0_o  <= '0;
            op1_o  <= '0;
            a0_o   <= '0;
            b0_o   <= '0;
            a1_o   <= '0;
            b1_o   <= '0;
        end else if (capture) begin
            fuse_o <= fuse_i;
            op0_o  <= op0_i;
            op1_o  <= op1_i;
            a0_o   <= a0_i;
            b0_o   <= b0_i;
            a1_o   <= a1_i;
            b1_o   <= b1_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/popcount.sv */
`default_nettype none

module popcount #(
    parameter int INPUT_WIDTH = 32
) (
    input  logic [INPUT_WIDTH-1:0]         data_i,
    output logic [$clog2(INPUT_WIDTH):0]   popcount_o
);

    localparam int LEVELS = $clog2(INPUT_WIDTH);
    localparam int PADDED = 1 << LEVELS;  // Leaves rounded up to a power of two
    localparam int CNT_W  = LEVELS + 1;

    logic [CNT_W-1:0] node [LEVELS+1][PADDED];

    for (genvar i = 0; i < PADDED; i++) begin : gen_leaf
        if (i < INPUT_WIDTH) begin : gen_bit
            assign node[0][i] = CNT_W'(data_i[i]);
        end else begin : gen_pad
            assign node[0][i] = '0;
        end
    end

    for (genvar l = 1; l <= LEVELS; l++) begin : gen_level
        for (genvar i = 0; i < PADDED; i++) begin : gen_node
            if (i < (PADDED >> l)) begin : gen_add
                assign node[l][i] = node[l-1][2*i] + node[l-1][2*i+1];
            end else begin : gen_unused
                assign node[l][i] = '0;
            end
        end
    end

    assign popcount_o = node[LEVELS][0];  // Root of the tree

endmodule

`default_nettype wire

/* hdl/result_return_master.sv */
`default_nettype none

module result_return_master #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            full_i,
    input  logic [XLEN-1:0] res0_i,
    input  logic [XLEN-1:0] res1_i,
    input  logic            branch_i,
    input  logic            res_ack_i,
    output logic            take_o,
    output logic            res_req_o,
    output logic [XLEN-1:0] res0_o,
    output logic [XLEN-1:0] res1_o,
    output logic            branch_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;  // Waiting for the receiver to release ack

    logic [1:0] state_q;

    assign take_o    = (state_q == ST_IDLE) & full_i;
    assign res_req_o = (state_q == ST_REQ);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (full_i) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (res_ack_i) begin
                        state_q <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (!res_ack_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res0_o   <= '0;
            res1_o   <= '0;
            branch_o <= 1'b0;
        end else if (take_o) begin
            res0_o   <= res0_i;  // Held stable for the whole output handshake
            res1_o   <= res1_i;
            branch_o <= branch_i;
        end
    end

endmodule

`default_nettype wire

/* verification/dual_alu_tb.sv */
`default_nettype none

module dual_alu_tb
    import alu_pkg::*;
();

    localparam int          XLEN     = 32;
    localparam bit          HAS_CPOP = 1'b1;
    localparam int          N_PAIRS  = 400;
    localparam int          N_OPS    = int'(OP_CPOPW) + 1;
    localparam int          TIMEOUT  = 500;
    localparam logic [31:0] SEED     = 32'hca14a9e2;

    logic              clk_i;
    logic              arst_n_i;
    logic              req_i;
    logic              ack_o;
    logic [FUSE_W-1:0] fuse_i;
    logic [OP_W-1:0]   op0_i;
    logic [OP_W-1:0]   op1_i;
    logic [XLEN-1:0]   a0_i;
    logic [XLEN-1:0]   b0_i;
    logic [XLEN-1:0]   a1_i;
    logic [XLEN-1:0]   b1_i;
    logic              res_req_o;
    logic              res_ack_i;
    logic [XLEN-1:0]   res0_o;
    logic [XLEN-1:0]   res1_o;
    logic              branch_o;

    logic [FUSE_W-1:0] fuse_q [$];  // Pairs the DUT has acknowledged, oldest first
    logic [OP_W-1:0]   op0_q  [$];
    logic [OP_W-1:0]   op1_q  [$];
    logic [XLEN-1:0]   a0_q   [$];
    logic [XLEN-1:0]   b0_q   [$];
    logic [XLEN-1:0]   a1_q   [$];
    logic [XLEN-1:0]   b1_q   [$];
    logic [31:0]       tx_rng;
    logic [31:0]       rx_rng;
    int                n_captured;
    int                n_returned;
    int                n_checked;

    dual_alu_top #(
        .XLEN    (XLEN),
        .HAS_CPOP(HAS_CPOP)
    ) u_dut (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .ack_o    (ack_o),
        .fuse_i   (fuse_i),
        .op0_i    (op0_i),
        .op1_i    (op1_i),
        .a0_i     (a0_i),
        .b0_i     (b0_i),
        .a1_i     (a1_i),
        .b1_i     (b1_i),
        .res_req_o(res_req_o),
        .res_ack_i(res_ack_i),
        .res0_o   (res0_o),
        .res1_o   (res1_o),
        .branch_o (branch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [XLEN-1:0] count_ones(input logic [XLEN-1:0] v, input int nbits);
        logic [XLEN-1:0] n;
        n = '0;
        for (int i = 0; i < nbits && i < XLEN; i++) begin
            n = n + v[i];
        end
        return n;
    endfunction

    // Flipping the sign bits turns a signed compare into an unsigned one
    function automatic logic signed_less(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [XLEN-1:0] sign;
        sign = {1'b1, {(XLEN-1){1'b0}}};
        return (a ^ sign) < (b ^ sign);
    endfunction

    function automatic logic branch_ref(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        case (op)
            OP_EQ:   return a == b;
            OP_NE:   return a != b;
            OP_LT:   return signed_less(a, b);
            OP_GE:   return !signed_less(a, b);
            OP_LTU:  return a < b;
            OP_GEU:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // Plain ALU lane where the popcount opcodes give zero
    function automatic logic [XLEN-1:0] alu_ref(input logic [OP_W-1:0] op,
                                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int              sh;
        logic [2*XLEN-1:0] wide;
        sh   = int'(b % XLEN);
        wide = {{XLEN{a[XLEN-1]}}, a} >> sh;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 1'b1;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return wide[XLEN-1:0];
            OP_SLT:  return {{(XLEN-1){1'b0}}, signed_less(a, b)};
            OP_SLTU: return {{(XLEN-1){1'b0}}, a < b};
            OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU: begin
                return {{(XLEN-1){1'b0}}, branch_ref(op, a, b)};
            end
            default: return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] lane_out(input logic [OP_W-1:0] op,
                                                 input logic [XLEN-1:0] alu_res,
                                                 input logic [XLEN-1:0] given_a);
        if (op == OP_CPOP) begin
            return HAS_CPOP ? count_ones(given_a, XLEN) : '0;
        end else if (op == OP_CPOPW) begin
            return HAS_CPOP ? count_ones(given_a, 32) : '0;
        end
        return alu_res;
    endfunction

    // Returns {branch, res1, res0} for one pair
    function automatic logic [2*XLEN:0] ref_pair(
        input logic [FUSE_W-1:0] fuse, input logic [OP_W-1:0] op0, input logic [OP_W-1:0] op1,
        input logic [XLEN-1:0] a0, input logic [XLEN-1:0] b0,
        input logic [XLEN-1:0] a1, input logic [XLEN-1:0] b1);
        logic [XLEN-1:0] alu1;
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
        alu1 = alu_ref(op1, a1, b1);
        opa  = fuse[FUSE_RS1] ? alu1 : a0;  // Lane 0 sees lane 1's ALU result, not its popcount
        opb  = fuse[FUSE_RS2] ? alu1 : b0;
        return {branch_ref(op1, a1, b1), lane_out(op1, alu1, a1),
                lane_out(op0, alu_ref(op0, opa, opb), a0)};
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_branch(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (ack_o !== level) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: input handshake stalled waiting for ack_o to be %0b", level);
                stop_with_failure();
            end
            cycles++;
            @(negedge clk_i);
        end
    endtask

    task automatic wait_res_req(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (res_req_o !== level) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: result handshake stalled waiting for res_req_o to be %0b",
                         level);
                stop_with_failure();
            end
            cycles++;
            @(negedge clk_i);
        end
    endtask

    initial begin
        arst_n_i   = 1'b0;
        req_i      = 1'b0;
        fuse_i     = '0;
        op0_i      = '0;
        op1_i      = '0;
        a0_i       = '0;
        b0_i       = '0;
        a1_i       = '0;
        b1_i       = '0;
        res_ack_i  = 1'b0;
        tx_rng     = SEED;
        rx_rng     = xorshift32(~SEED);  // Own stream so the receiver is independent of the sender
        n_captured = 0;
        n_returned = 0;
        n_checked  = 0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("ack_o", 1'b0, ack_o);
        check_flag("res_req_o", 1'b0, res_req_o);
        check_result("res0_o", '0, res0_o);

        fork
            begin : sender
                int              gap;
                logic [XLEN-1:0] a0_val;
                for (int n = 0; n < N_PAIRS; n++) begin
                    tx_rng = xorshift32(tx_rng);
                    gap    = (tx_rng[2:0] == 3'd0) ? int'(tx_rng[5:3]) : 0;
                    repeat (gap) @(posedge clk_i);
                    @(posedge clk_i);
                    fuse_i <= (n < N_PAIRS / 3) ? '0 : tx_rng[9:8];  // No fusion at first
                    op0_i  <= OP_W'(tx_rng[31:16] % N_OPS);
                    tx_rng = xorshift32(tx_rng);
                    op1_i  <= OP_W'(tx_rng[31:16] % N_OPS);
                    a0_val = xorshift32(tx_rng);
                    a0_i   <= a0_val;
                    tx_rng = xorshift32(xorshift32(tx_rng));
                    b0_i   <= tx_rng[3:0] == 4'd0 ? a0_val : xorshift32(tx_rng);
                    tx_rng = xorshift32(xorshift32(tx_rng));
                    a1_i   <= tx_rng;
                    b1_i   <= tx_rng[5:4] == 2'd0 ? tx_rng : xorshift32(tx_rng);
                    tx_rng = xorshift32(tx_rng);
                    req_i  <= 1'b1;
                    wait_ack(1'b1);
                    fuse_q.push_back(fuse_i);
                    op0_q.push_back(op0_i);
                    op1_q.push_back(op1_i);
                    a0_q.push_back(a0_i);
                    b0_q.push_back(b0_i);
                    a1_q.push_back(a1_i);
                    b1_q.push_back(b1_i);
                    n_captured++;
                    if (n_captured - n_returned > 1) begin
                        $display("More than two pairs accepted while the output was blocked");
                        stop_with_failure();
                    end
                    if (n == 0) begin
                        check_flag("res_req_o", 1'b0, res_req_o);  // One cycle after capture
                        @(negedge clk_i);
                        check_flag("res_req_o", 1'b1, res_req_o);
                    end
                    @(posedge clk_i);
                    req_i <= 1'b0;
                    wait_ack(1'b0);
                end
            end
            begin : receiver
                logic [2*XLEN:0] expected;
                int              delay;
                for (int n = 0; n < N_PAIRS; n++) begin
                    wait_res_req(1'b1);
                    n_returned++;
                    if (fuse_q.size() == 0) begin
                        $display("A result pair came back with no pair outstanding");
                        stop_with_failure();
                    end
                    expected = ref_pair(fuse_q.pop_front(), op0_q.pop_front(),
                                        op1_q.pop_front(), a0_q.pop_front(), b0_q.pop_front(),
                                        a1_q.pop_front(), b1_q.pop_front());
                    check_result("res0_o", expected[XLEN-1:0], res0_o);
                    check_result("res1_o", expected[2*XLEN-1:XLEN], res1_o);
                    check_branch("branch_o", expected[2*XLEN], branch_o);
                    rx_rng = xorshift32(rx_rng);
                    delay  = int'(rx_rng[3:0]);
                    if (rx_rng[7:5] == 3'd0) begin
                        delay = 20 + int'(rx_rng[12:8]);  // Long stall to build back-pressure
                    end
                    repeat (delay) @(posedge clk_i);
                    @(posedge clk_i);
                    res_ack_i <= 1'b1;
                    wait_res_req(1'b0);
                    @(posedge clk_i);
                    res_ack_i <= 1'b0;
                    n_checked++;
                end
            end
        join

        if (n_checked == N_PAIRS && fuse_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Only %0d of %0d result pairs were checked", n_checked, N_PAIRS);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
